// File: vlog.f
design/fetch_queue_pkg.sv
design/sdp_ram.sv
design/sync_fifo.sv
design/fetch_capture.sv
design/issue_stage.sv
design/fetch_queue_top.sv
dv/fetch_queue_tb.sv

// File: dv/fetch_queue_tb.sv
// ==================================================
// fetch queue testbench
// directed tests checked against a cycle-level
// model of capture, queue and issue
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_queue_tb;

  localparam int unsigned QUEUE_DEPTH = 8;
  localparam bit          BYPASS_EN   = 1'b1;
  localparam int unsigned CNT_W       = $clog2(QUEUE_DEPTH + 1);
  // cycle budget, reset then tests one to five
  localparam int TEST_CYCLES    = 8 + 2 + 14 + 28 + 18 + 232;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                       clk;
  logic                       rst_n;
  logic                       fetch_valid_i;
  fetch_queue_pkg::pc_t       fetch_pc_i;
  fetch_queue_pkg::instr_t    fetch_instr_i;
  logic                       redirect_i;
  logic                       issue_en_i;
  logic                       issue_valid_o;
  fetch_queue_pkg::pc_t       issue_pc_o;
  fetch_queue_pkg::instr_t    issue_instr_o;
  logic                       issue_ctrl_o;
  logic [CNT_W-1:0]           queue_usage_o;
  fetch_queue_pkg::drop_cnt_t drop_cnt_o;

  // ==================================================
  // reference model state
  // ==================================================

  // pair strobed last cycle, waiting for push
  logic                       pend_valid_m;
  fetch_queue_pkg::entry_t    pend_entry_m;
  // queued pairs, oldest first
  fetch_queue_pkg::entry_t    queue_m [$];
  // entry expected on the issue port this cycle
  logic                       exp_valid_m;
  fetch_queue_pkg::entry_t    exp_entry_m;
  fetch_queue_pkg::drop_cnt_t drop_m;

  logic [31:0] lfsr_q;
  int          cycle_cnt = 0;
  int          err_cnt = 0;

  fetch_queue_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .BYPASS_EN   (BYPASS_EN)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i),
    .redirect_i    (redirect_i),
    .issue_en_i    (issue_en_i),
    .issue_valid_o (issue_valid_o),
    .issue_pc_o    (issue_pc_o),
    .issue_instr_o (issue_instr_o),
    .issue_ctrl_o  (issue_ctrl_o),
    .queue_usage_o (queue_usage_o),
    .drop_cnt_o    (drop_cnt_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  // ==================================================
  // helpers
  // ==================================================

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // branch, jal or jalr opcode
  function automatic logic control_flow(input fetch_queue_pkg::instr_t instr);
    return (instr[6:0] == fetch_queue_pkg::OPC_BRANCH) ||
           (instr[6:0] == fetch_queue_pkg::OPC_JAL) ||
           (instr[6:0] == fetch_queue_pkg::OPC_JALR);
  endfunction

  // one clock of fetch and redirect stimulus
  task automatic drive_cycle(input logic valid, input fetch_queue_pkg::pc_t pc,
                             input fetch_queue_pkg::instr_t instr, input logic redirect);
    @(posedge clk);
    fetch_valid_i <= valid;
    fetch_pc_i    <= pc;
    fetch_instr_i <= instr;
    redirect_i    <= redirect;
  endtask

  task automatic drive_idle();
    drive_cycle(1'b0, '0, '0, 1'b0);
  endtask

  task automatic wait_issue(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!issue_valid_o) begin
      if (waited >= limit) begin
        $display("no issue strobe seen within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1);
      end
      waited++;
      @(negedge clk);
    end
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while ((queue_usage_o != 0) || issue_valid_o) begin
      if (waited >= limit) begin
        $display("queue did not drain within %0d cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1);
      end
      waited++;
      @(negedge clk);
    end
  endtask

  // ==================================================
  // model and monitor
  // ==================================================

  task automatic reset_model();
    pend_valid_m = 1'b0;
    queue_m.delete();
    exp_valid_m = 1'b0;
    drop_m = '0;
  endtask

  task automatic compare_outputs();
    check_value("issue_valid_o", exp_valid_m, issue_valid_o);
    if (exp_valid_m) begin
      check_value("issue_pc_o", exp_entry_m[63:32], issue_pc_o);
      check_value("issue_instr_o", exp_entry_m[31:0], issue_instr_o);
      check_value("issue_ctrl_o", control_flow(exp_entry_m[31:0]), issue_ctrl_o);
    end
    check_value("queue_usage_o", queue_m.size(), queue_usage_o);
    check_value("drop_cnt_o", drop_m, drop_cnt_o);
  endtask

  // advance one clock with the inputs of this cycle
  task automatic step_model();
    logic live;
    logic push;
    logic head_empty;
    logic pop;
    live = pend_valid_m && !redirect_i;
    push = live && (queue_m.size() < QUEUE_DEPTH);
    // full queue loses the pair
    if (live && !push && (drop_m != '1)) begin
      drop_m = drop_m + 1'b1;
    end
    head_empty = (queue_m.size() == 0) && !(BYPASS_EN && push);
    pop = issue_en_i && !head_empty && !redirect_i;
    if (push) begin
      queue_m.push_back(pend_entry_m);
    end
    exp_valid_m = pop;
    if (pop) begin
      exp_entry_m = queue_m.pop_front();
    end
    if (redirect_i) begin
      queue_m.delete();
    end
    pend_valid_m = fetch_valid_i;
    pend_entry_m = {fetch_pc_i, fetch_instr_i};
  endtask

  // mid-cycle, inputs and outputs both settled
  always @(negedge clk) begin
    if (!rst_n) begin
      reset_model();
    end else begin
      compare_outputs();
      step_model();
    end
  end

  // ==================================================
  // tests
  // ==================================================

  task automatic reset_state_test();
    @(negedge clk);
    check_value("issue_valid_o", 1'b0, issue_valid_o);
    check_value("queue_usage_o", 0, queue_usage_o);
    check_value("drop_cnt_o", 0, drop_cnt_o);
  endtask

  // empty queue, strobe out two cycles later
  task automatic bypass_latency_test();
    fetch_queue_pkg::pc_t    pc;
    fetch_queue_pkg::instr_t instr;
    drive_idle();
    issue_en_i <= 1'b1;
    for (int k = 0; k < 4; k++) begin
      pc = 32'h0000_1000 + 4 * k;
      instr = rand_bits(32);
      drive_cycle(1'b1, pc, instr, 1'b0);
      drive_idle();
      @(negedge clk);
      check_value("issue_valid_o", 1'b0, issue_valid_o);
      drive_idle();
      @(negedge clk);
      check_value("issue_valid_o", 1'b1, issue_valid_o);
      check_value("issue_pc_o", pc, issue_pc_o);
      check_value("issue_instr_o", instr, issue_instr_o);
      check_value("queue_usage_o", 0, queue_usage_o);
    end
  endtask

  // eleven strobes into eight slots, then drain
  task automatic fill_overflow_test();
    fetch_queue_pkg::instr_t instrs [11];
    drive_idle();
    issue_en_i <= 1'b0;
    for (int k = 0; k < 11; k++) begin
      instrs[k] = rand_bits(32);
      drive_cycle(1'b1, 32'h0000_2000 + 4 * k, instrs[k], 1'b0);
    end
    drive_idle();
    drive_idle();
    @(negedge clk);
    check_value("queue_usage_o", QUEUE_DEPTH, queue_usage_o);
    check_value("drop_cnt_o", 3, drop_cnt_o);
    drive_idle();
    issue_en_i <= 1'b1;
    wait_issue(4);
    // first eight back to back
    for (int k = 0; k < 8; k++) begin
      check_value("issue_valid_o", 1'b1, issue_valid_o);
      check_value("issue_pc_o", 32'h0000_2000 + 4 * k, issue_pc_o);
      check_value("issue_instr_o", instrs[k], issue_instr_o);
      @(negedge clk);
    end
    check_value("issue_valid_o", 1'b0, issue_valid_o);
    check_value("queue_usage_o", 0, queue_usage_o);
  endtask

  task automatic redirect_test();
    fetch_queue_pkg::instr_t target_instr;
    fetch_queue_pkg::instr_t next_instr;
    drive_idle();
    issue_en_i <= 1'b0;
    for (int k = 0; k < 3; k++) begin
      drive_cycle(1'b1, 32'h0000_3000 + 4 * k, rand_bits(32), 1'b0);
    end
    drive_idle();
    drive_idle();
    @(negedge clk);
    check_value("queue_usage_o", 3, queue_usage_o);
    target_instr = rand_bits(32);
    next_instr = rand_bits(32);
    // redirect carries its own target pair
    drive_cycle(1'b1, 32'h0000_4000, target_instr, 1'b1);
    // decode enabled only in the redirect cycle, the flush alone holds the pop
    issue_en_i <= 1'b1;
    drive_cycle(1'b1, 32'h0000_4004, next_instr, 1'b0);
    issue_en_i <= 1'b0;
    @(negedge clk);
    check_value("issue_valid_o", 1'b0, issue_valid_o);
    check_value("queue_usage_o", 0, queue_usage_o);
    drive_idle();
    @(negedge clk);
    check_value("queue_usage_o", 1, queue_usage_o);
    drive_idle();
    issue_en_i <= 1'b1;
    wait_issue(4);
    check_value("issue_pc_o", 32'h0000_4000, issue_pc_o);
    check_value("issue_instr_o", target_instr, issue_instr_o);
    @(negedge clk);
    check_value("issue_valid_o", 1'b1, issue_valid_o);
    check_value("issue_pc_o", 32'h0000_4004, issue_pc_o);
    check_value("issue_instr_o", next_instr, issue_instr_o);
    @(negedge clk);
    check_value("issue_valid_o", 1'b0, issue_valid_o);
    check_value("queue_usage_o", 0, queue_usage_o);
  endtask

  // fetch faster than issue, so the queue fills now and then
  task automatic random_stream_test();
    fetch_queue_pkg::pc_t    pc;
    fetch_queue_pkg::instr_t instr;
    logic                    valid;
    logic [1:0]              sel;
    pc = 32'h0000_8000;
    for (int c = 0; c < 200; c++) begin
      valid = (rand_bits(2) != 0);
      instr = rand_bits(32);
      // one in four gets a control-flow opcode
      if (rand_bits(2) == 0) begin
        sel = 2'(rand_bits(2));
        case (sel)
          2'd0:    instr[6:0] = fetch_queue_pkg::OPC_BRANCH;
          2'd1:    instr[6:0] = fetch_queue_pkg::OPC_JAL;
          default: instr[6:0] = fetch_queue_pkg::OPC_JALR;
        endcase
      end
      drive_cycle(valid, pc, instr, 1'b0);
      issue_en_i <= lfsr_bit();
      if (valid) begin
        pc = pc + 4;
      end
    end
    drive_idle();
    issue_en_i <= 1'b1;
    drive_idle();
    wait_drained(2 * QUEUE_DEPTH + 4);
    check_value("drop_cnt_o", drop_m, drop_cnt_o);
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    lfsr_q = 32'h3266;
    rst_n = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pc_i = '0;
    fetch_instr_i = '0;
    redirect_i = 1'b0;
    issue_en_i = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_state_test();
    bypass_latency_test();
    fill_overflow_test();
    redirect_test();
    random_stream_test();
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : fetch_queue_tb

`default_nettype wire

// File: design/fetch_queue_top.sv
// ==================================================
// instruction fetch queue top level
// capture stage, FIFO and issue stage
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_queue_top #(
  parameter int unsigned  QUEUE_DEPTH = 8,
  parameter bit           BYPASS_EN   = 1'b1,
  localparam int unsigned CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // fetch source
  input  wire logic                      fetch_valid_i,
  input  wire fetch_queue_pkg::pc_t      fetch_pc_i,
  input  wire fetch_queue_pkg::instr_t   fetch_instr_i,
  // control
  input  wire logic                      redirect_i,
  input  wire logic                      issue_en_i,
  // towards decode
  output logic                           issue_valid_o,
  output fetch_queue_pkg::pc_t           issue_pc_o,
  output fetch_queue_pkg::instr_t        issue_instr_o,
  output logic                           issue_ctrl_o,
  // status
  output logic [CNT_W-1:0]               queue_usage_o,
  output fetch_queue_pkg::drop_cnt_t     drop_cnt_o
);

  // capture to FIFO
  logic                    push;
  fetch_queue_pkg::entry_t push_data;
  logic                    full;
  // FIFO to issue
  logic                    pop;
  logic                    empty;
  fetch_queue_pkg::entry_t head_data;
  // issued entry before the split
  fetch_queue_pkg::entry_t issue_data;

  // ==================================================
  // stages
  // ==================================================

  fetch_capture u_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i),
    .full_i        (full),
    .push_o        (push),
    .push_data_o   (push_data),
    .drop_cnt_o    (drop_cnt_o)
  );

  // redirect flushes the queue as well
  sync_fifo #(
    .DEPTH     (QUEUE_DEPTH),
    .BYPASS_EN (BYPASS_EN)
  ) u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .head_data_o (head_data),
    .empty_o     (empty),
    .full_o      (full),
    .usage_o     (queue_usage_o)
  );

  issue_stage u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .issue_en_i    (issue_en_i),
    .empty_i       (empty),
    .head_data_i   (head_data),
    .pop_o         (pop),
    .issue_valid_o (issue_valid_o),
    .issue_data_o  (issue_data),
    .issue_ctrl_o  (issue_ctrl_o)
  );

  // ==================================================
  // entry split
  // ==================================================

  // pc upper half, instruction lower half
  assign issue_pc_o    = issue_data[2*fetch_queue_pkg::XLEN-1:fetch_queue_pkg::XLEN];
  assign issue_instr_o = issue_data[fetch_queue_pkg::XLEN-1:0];

endmodule : fetch_queue_top

`default_nettype wire

// File: design/issue_stage.sv
// ==================================================
// issue stage
// pops the queue head towards decode and flags
// control-flow instructions
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     redirect_i,
  // decode enable level
  input  wire logic                     issue_en_i,
  // queue side
  input  wire logic                     empty_i,
  input  wire fetch_queue_pkg::entry_t  head_data_i,
  output logic                          pop_o,
  // towards decode
  output logic                          issue_valid_o,
  output fetch_queue_pkg::entry_t       issue_data_o,
  output logic                          issue_ctrl_o
);

  // instruction half of the head entry
  fetch_queue_pkg::instr_t head_instr;
  logic [6:0]              head_opcode;
  // head is a branch or jump
  logic                    head_ctrl;

  // ==================================================
  // pop
  // ==================================================

  // redirect blocks the pop, head may be stale
  assign pop_o = issue_en_i && !empty_i && !redirect_i;

  // ==================================================
  // predecode
  // ==================================================

  assign head_instr  = head_data_i[fetch_queue_pkg::XLEN-1:0];
  assign head_opcode = head_instr[6:0];

  // branch, jal and jalr count as control flow
  assign head_ctrl = (head_opcode == fetch_queue_pkg::OPC_BRANCH) ||
                     (head_opcode == fetch_queue_pkg::OPC_JAL)    ||
                     (head_opcode == fetch_queue_pkg::OPC_JALR);

  // ==================================================
  // output register
  // ==================================================

  // one-cycle strobe per popped entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= pop_o;
    end
  end

  // payload and flag, only meaningful with the strobe
  always_ff @(posedge clk) begin
    if (pop_o) begin
      issue_data_o <= head_data_i;
      issue_ctrl_o <= head_ctrl;
    end
  end

endmodule : issue_stage

`default_nettype wire

// File: design/fetch_capture.sv
// ==================================================
// fetch capture stage
// registers fetch strobes, pushes them into the queue
// and counts pairs dropped on a full queue
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module fetch_capture (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      redirect_i,
  // fetch source, one strobe per pair
  input  wire logic                      fetch_valid_i,
  input  wire fetch_queue_pkg::pc_t      fetch_pc_i,
  input  wire fetch_queue_pkg::instr_t   fetch_instr_i,
  // queue side
  input  wire logic                      full_i,
  output logic                           push_o,
  output fetch_queue_pkg::entry_t        push_data_o,
  // status
  output fetch_queue_pkg::drop_cnt_t     drop_cnt_o
);

  // pending pair from last cycle
  logic                       pending_q;
  fetch_queue_pkg::entry_t    entry_q;
  fetch_queue_pkg::drop_cnt_t drop_cnt_q;

  // pending pair that has to go somewhere this cycle
  logic live;
  logic drop;

  // ==================================================
  // capture register
  // ==================================================

  // flag follows the strobe, so a redirect leaves
  // only the pair arriving with it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= fetch_valid_i;
    end
  end

  // payload, pc on top
  always_ff @(posedge clk) begin
    if (fetch_valid_i) begin
      entry_q <= {fetch_pc_i, fetch_instr_i};
    end
  end

  // ==================================================
  // push or drop
  // ==================================================

  // redirect kills the pending pair
  assign live = pending_q && !redirect_i;

  // no room, pair is lost
  assign drop = live && full_i;

  assign push_o      = live && !full_i;
  assign push_data_o = entry_q;

  // saturating drop counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt_q <= '0;
    end else if (drop && (drop_cnt_q != '1)) begin
      drop_cnt_q <= drop_cnt_q + 1'b1;
    end
  end

  assign drop_cnt_o = drop_cnt_q;

endmodule : fetch_capture

`default_nettype wire

// File: design/sync_fifo.sv
// ==================================================
// synchronous FIFO on a simple dual-port RAM
// wrapping pointers, occupancy count, flush and
// optional bypass around an empty queue
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int unsigned  DEPTH     = 8,
  parameter bit           BYPASS_EN = 1'b1,
  localparam int unsigned ADDR_W    = $clog2(DEPTH),
  localparam int unsigned CNT_W     = $clog2(DEPTH + 1)
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     flush_i,
  // write side, caller checks full
  input  wire logic                     push_i,
  input  wire fetch_queue_pkg::entry_t  push_data_i,
  // read side, caller checks empty
  input  wire logic                     pop_i,
  output fetch_queue_pkg::entry_t       head_data_o,
  // status
  output logic                          empty_o,
  output logic                          full_o,
  output logic [CNT_W-1:0]              usage_o
);

  // last valid ram address, wrap point
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

  // ==================================================
  // state
  // ==================================================

  logic [ADDR_W-1:0] rd_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_n;
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] wr_ptr_n;
  logic [CNT_W-1:0]  count_q;
  logic [CNT_W-1:0]  count_n;

  // queue has nothing stored
  logic ram_empty;
  // push goes straight to the head, bypassing storage
  logic bypass;

  fetch_queue_pkg::entry_t ram_rdata;

  assign ram_empty = (count_q == '0);
  assign bypass    = BYPASS_EN && ram_empty && push_i;

  // ==================================================
  // storage
  // ==================================================

  // read address runs one step ahead so data lands with the pointer
  sdp_ram #(
    .DEPTH (DEPTH)
  ) u_ram (
    .clk     (clk),
    .we_i    (push_i),
    .waddr_i (wr_ptr_q),
    .wdata_i (push_data_i),
    .raddr_i (rd_ptr_n),
    .rdata_o (ram_rdata)
  );

  // ==================================================
  // status and head
  // ==================================================

  assign usage_o     = count_q;
  assign full_o      = (count_q == CNT_W'(DEPTH));
  assign empty_o     = ram_empty && !bypass;
  assign head_data_o = bypass ? push_data_i : ram_rdata;

  // ==================================================
  // next pointers and count
  // ==================================================

  always_comb begin
    rd_ptr_n = rd_ptr_q;
    wr_ptr_n = wr_ptr_q;
    count_n  = count_q;

    if (bypass && pop_i) begin
      // pushed entry consumed in flight, nothing moves
      count_n = count_q;
    end else begin
      // write pointer advance, wraps for non power of two depths
      if (push_i) begin
        wr_ptr_n = (wr_ptr_q == LAST_ADDR) ? '0 : wr_ptr_q + 1'b1;
      end
      // read pointer advance
      if (pop_i) begin
        rd_ptr_n = (rd_ptr_q == LAST_ADDR) ? '0 : rd_ptr_q + 1'b1;
      end
      // occupancy, push plus pop cancels out
      case ({push_i, pop_i})
        2'b10:   count_n = count_q + 1'b1;
        2'b01:   count_n = count_q - 1'b1;
        default: count_n = count_q;
      endcase
    end
  end

  // ==================================================
  // registers
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect, drop everything queued
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_n;
      wr_ptr_q <= wr_ptr_n;
      count_q  <= count_n;
    end
  end

endmodule : sync_fifo

`default_nettype wire

// File: design/sdp_ram.sv
// ==================================================
// simple dual-port RAM
// one write port, one registered write-first read port
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter int unsigned DEPTH = 8,
  localparam int unsigned ADDR_W = $clog2(DEPTH)
) (
  input  wire logic                     clk,
  // write port
  input  wire logic                     we_i,
  input  wire logic [ADDR_W-1:0]        waddr_i,
  input  wire fetch_queue_pkg::entry_t  wdata_i,
  // read port
  input  wire logic [ADDR_W-1:0]        raddr_i,
  output fetch_queue_pkg::entry_t       rdata_o
);

  // storage array, no reset on contents
  fetch_queue_pkg::entry_t mem [DEPTH];

  // write side
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read side, registered
  // collision returns the word being written this cycle
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule : sdp_ram

`default_nettype wire

// File: design/fetch_queue_pkg.sv
// ==================================================
// fetch queue shared definitions
// widths, entry layout and control-flow opcodes
// ==================================================

`default_nettype none

package fetch_queue_pkg;

  // ==================================================
  // widths
  // ==================================================

  // pc and instruction width
  parameter int unsigned XLEN = 32;

  // program counter
  typedef logic [XLEN-1:0] pc_t;

  // raw instruction word
  typedef logic [XLEN-1:0] instr_t;

  // one queue entry, pc in upper half, instruction in lower half
  typedef logic [2*XLEN-1:0] entry_t;

  // saturating drop counter
  typedef logic [7:0] drop_cnt_t;

  // ==================================================
  // control-flow opcodes
  // ==================================================

  // conditional branches
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  // jump and link
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  // jump and link register
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage : fetch_queue_pkg

`default_nettype wire
